// ==== hw/bus_frame_pkg.sv ====
// Bus frame definitions: phase numbering, bus widths and the write flag position on the pins
`default_nettype none

package bus_frame_pkg;

  // Bus word geometry
  localparam int word_bytes = 4;              // Bytes per bus word
  localparam int word_w     = 8 * word_bytes; // Bus word width

  // Frame phase counter
  localparam int phase_w = 4;

  localparam logic [phase_w-1:0] ph_step  = 4'd0; // CPU step strobe, pins quiet
  localparam logic [phase_w-1:0] ph_addr0 = 4'd1; // Address byte 0, write data byte 0
  localparam logic [phase_w-1:0] ph_addr1 = 4'd2;
  localparam logic [phase_w-1:0] ph_addr2 = 4'd3;
  localparam logic [phase_w-1:0] ph_addr3 = 4'd4; // Address byte 3, write data byte 3
  localparam logic [phase_w-1:0] ph_flag  = 4'd5; // Write flag on uo_out
  localparam logic [phase_w-1:0] ph_read0 = 4'd6; // Read byte 0 on uio_in
  localparam logic [phase_w-1:0] ph_read1 = 4'd7;
  localparam logic [phase_w-1:0] ph_read2 = 4'd8;
  localparam logic [phase_w-1:0] ph_read3 = 4'd9; // Last read byte

  // Active phases per frame, idle gap comes on top
  localparam int frame_phases = 10;

  // Write flag sits in uo_out bit 0 during ph_flag
  localparam int flag_bit = 0;

  // Output enable patterns on the bidirectional pins
  localparam logic [7:0] oe_drive = 8'hff;
  localparam logic [7:0] oe_float = 8'h00;

endpackage

`default_nettype wire

// ==== hw/cpu_isa_pkg.sv ====
// Accumulator CPU instruction set: opcode encoding and instruction word layout
`default_nettype none

package cpu_isa_pkg;

  localparam int instr_w   = 32; // Instruction and data word width
  localparam int opcode_w  = 4;  // Bits 31:28
  localparam int operand_w = 28; // Bits 27:0, zero-extended on use

  // Opcodes
  // Any encoding not listed below behaves like op_halt
  typedef enum logic [opcode_w-1:0] {
    op_load  = 4'h1, // acc = mem[operand]
    op_store = 4'h2, // mem[operand] = acc
    op_addi  = 4'h3, // acc = acc + operand, wraps at 2**32
    op_jump  = 4'h4, // pc = operand
    op_halt  = 4'hf  // pc stays, same word fetched again
  } opcode_e;

  // Instruction word as seen on the bus
  typedef struct packed {
    opcode_e                opcode;
    logic [operand_w-1:0]   operand;
  } instr_t;

  // Opcode field position
  localparam int opcode_lsb = operand_w;
  localparam int opcode_msb = instr_w - 1;

endpackage

`default_nettype wire

// ==== hw/cpu_bus_if.sv ====
// CPU bus interface: one word access from the CPU and the read word gathered off the pins
`timescale 1ns/1ns
`default_nettype none

interface cpu_bus_if;

  logic [bus_frame_pkg::word_w-1:0] addr;  // Word address
  logic [bus_frame_pkg::word_w-1:0] wdata; // Store data
  logic                             write; // High for a store
  logic [bus_frame_pkg::word_w-1:0] rdata; // Read word, complete after the read window
  logic                             step;  // One cycle per frame, in phase 0

  modport cpu (
    output addr,
    output wdata,
    output write,
    input  rdata,
    input  step
  );

  // Pin side, shared by the sequencer (step) and the serializer (rdata)
  modport pins (
    input  addr,
    input  wdata,
    input  write,
    output rdata,
    output step
  );

endinterface

`default_nettype wire

// ==== hw/frame_sequencer.sv ====
// Frame sequencer: walks phases 0 to 9, adds the idle gap and strobes the CPU step
`timescale 1ns/1ns
`default_nettype none

module frame_sequencer #(
  parameter int idle_cycles = 0 // Idle cycles after phase 9
) (
  input  logic                              clk,
  input  logic                              rst_n,
  output logic [bus_frame_pkg::phase_w-1:0] phase, // Phase of the coming cycle
  output logic                              idle,  // Coming cycle is in the idle gap
  cpu_bus_if.pins                           bus
);

  localparam int frame_len = bus_frame_pkg::frame_phases + idle_cycles;
  localparam int cnt_w     = $clog2(frame_len);

  logic [cnt_w-1:0] cnt_q;   // Position in frame, 0 is the step phase
  logic [cnt_w-1:0] cnt_nxt;
  logic             wrap;

  assign wrap    = (cnt_q == cnt_w'(frame_len - 1));
  assign cnt_nxt = wrap ? '0 : cnt_q + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0; // First cycle after reset is phase 0
    end else begin
      cnt_q <= cnt_nxt;
    end
  end

  // Look one cycle ahead so the pin registers line up with the phase
  assign idle  = (cnt_nxt >= cnt_w'(bus_frame_pkg::frame_phases));
  assign phase = idle ? bus_frame_pkg::ph_step : cnt_nxt[bus_frame_pkg::phase_w-1:0];

  // Step marks the current cycle as phase 0
  assign bus.step = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== hw/pin_serializer.sv ====
// Pin serializer: spreads one bus access over the frame phases and gathers the read bytes
`timescale 1ns/1ns
`default_nettype none

module pin_serializer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [bus_frame_pkg::phase_w-1:0] phase,  // Phase of the coming cycle
  input  logic                              idle,   // Coming cycle is in the idle gap
  cpu_bus_if.pins                           bus,
  input  logic [7:0]                        uio_in,
  output logic [7:0]                        uo_out,
  output logic [7:0]                        uio_out,
  output logic [7:0]                        uio_oe
);

  localparam int word_w = bus_frame_pkg::word_w;

  logic [word_w-1:0]                 addr_q;   // Access held for phases 2 to 5
  logic [word_w-1:0]                 wdata_q;
  logic                              write_q;
  logic [word_w-1:0]                 addr_sel;
  logic [word_w-1:0]                 wdata_sel;
  logic                              write_sel;
  logic [bus_frame_pkg::phase_w-1:0] cur_phase_q; // Phase of the current cycle
  logic [1:0]                        byte_idx;
  logic                              in_addr;
  logic                              in_flag;
  logic                              in_read;
  logic [7:0]                        uo_nxt;
  logic [7:0]                        uio_nxt;
  logic [7:0]                        oe_nxt;

  assign in_addr = !idle && (phase >= bus_frame_pkg::ph_addr0) &&
                   (phase <= bus_frame_pkg::ph_addr3);
  assign in_flag = !idle && (phase == bus_frame_pkg::ph_flag);
  assign in_read = (cur_phase_q >= bus_frame_pkg::ph_read0) &&
                   (cur_phase_q <= bus_frame_pkg::ph_read3);

  // Take the access as the frame moves into phase 1
  always_ff @(posedge clk) begin
    if (!idle && phase == bus_frame_pkg::ph_addr0) begin
      addr_q  <= bus.addr;
      wdata_q <= bus.wdata;
      write_q <= bus.write;
    end
  end

  // Phase 1 byte is loaded on the same edge as the latch, so bypass it
  assign addr_sel  = (phase == bus_frame_pkg::ph_addr0) ? bus.addr  : addr_q;
  assign wdata_sel = (phase == bus_frame_pkg::ph_addr0) ? bus.wdata : wdata_q;
  assign write_sel = (phase == bus_frame_pkg::ph_addr0) ? bus.write : write_q;

  assign byte_idx = phase[1:0] - 2'd1; // Phases 1..4 give bytes 0..3, LSB first

  always_comb begin
    uo_nxt  = '0;
    uio_nxt = '0;
    oe_nxt  = bus_frame_pkg::oe_float;
    if (in_addr) begin
      uo_nxt  = addr_sel[8*byte_idx +: 8];
      uio_nxt = write_sel ? wdata_sel[8*byte_idx +: 8] : 8'h00;
      oe_nxt  = bus_frame_pkg::oe_drive;
    end else if (in_flag) begin
      uo_nxt[bus_frame_pkg::flag_bit] = write_sel;
      oe_nxt = bus_frame_pkg::oe_drive;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uo_out      <= '0;
      uio_out     <= '0;
      uio_oe      <= bus_frame_pkg::oe_float;
      cur_phase_q <= bus_frame_pkg::ph_step;
    end else begin
      uo_out      <= uo_nxt;
      uio_out     <= uio_nxt;
      uio_oe      <= oe_nxt;
      cur_phase_q <= phase;
    end
  end

  // Bytes arrive LSB first, shift in from the top
  always_ff @(posedge clk) begin
    if (in_read) begin
      bus.rdata <= {uio_in, bus.rdata[word_w-1:8]};
    end
  end

endmodule

`default_nettype wire

// ==== hw/accum_cpu.sv ====
// Accumulator CPU: fetches and executes one instruction word per bus frame
`timescale 1ns/1ns
`default_nettype none

module accum_cpu (
  input  logic   clk,
  input  logic   rst_n,
  cpu_bus_if.cpu bus
);

  localparam int word_w = cpu_isa_pkg::instr_w;

  typedef enum logic {
    st_fetch, // Access in flight is an instruction fetch
    st_exec   // Access in flight is the data access of a load or store
  } state_e;

  state_e               state_q;
  state_e               state_nxt;
  logic                 busy_q;     // An access is in flight
  logic [word_w-1:0]    pc_q;
  logic [word_w-1:0]    pc_nxt;
  logic [word_w-1:0]    acc_q;
  logic [word_w-1:0]    acc_nxt;
  cpu_isa_pkg::instr_t  ir_q;       // Instruction under execution
  cpu_isa_pkg::instr_t  fetched;
  logic [word_w-1:0]    operand_ext;
  logic [word_w-1:0]    req_addr;
  logic                 req_write;

  assign fetched     = bus.rdata;
  assign operand_ext = {{cpu_isa_pkg::opcode_w{1'b0}}, fetched.operand};

  // Next state and next access, both valid while step is high
  always_comb begin
    state_nxt = state_q;
    pc_nxt    = pc_q;
    acc_nxt   = acc_q;
    req_addr  = pc_q;
    req_write = 1'b0;
    if (!busy_q) begin
      req_addr = pc_q; // Nothing returned yet, first fetch
    end else if (state_q == st_fetch) begin
      case (fetched.opcode)
        cpu_isa_pkg::op_load: begin
          state_nxt = st_exec;
          req_addr  = operand_ext;
        end
        cpu_isa_pkg::op_store: begin
          state_nxt = st_exec;
          req_addr  = operand_ext;
          req_write = 1'b1;
        end
        cpu_isa_pkg::op_addi: begin
          acc_nxt  = acc_q + operand_ext; // Wraps modulo 2**32
          pc_nxt   = pc_q + 1'b1;
          req_addr = pc_q + 1'b1;
        end
        cpu_isa_pkg::op_jump: begin
          pc_nxt   = operand_ext;
          req_addr = operand_ext;
        end
        default: begin
          req_addr = pc_q; // Halt, fetch the same word again
        end
      endcase
    end else begin
      if (ir_q.opcode == cpu_isa_pkg::op_load) begin
        acc_nxt = bus.rdata; // Load data is back
      end
      state_nxt = st_fetch;
      pc_nxt    = pc_q + 1'b1;
      req_addr  = pc_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_fetch;
      busy_q  <= 1'b0;
      pc_q    <= '0;
      acc_q   <= '0;
    end else if (bus.step) begin
      state_q <= state_nxt;
      busy_q  <= 1'b1;
      pc_q    <= pc_nxt;
      acc_q   <= acc_nxt;
    end
  end

  // Keep the fetched word for the execute frame
  always_ff @(posedge clk) begin
    if (bus.step && busy_q && state_q == st_fetch) begin
      ir_q <= fetched;
    end
  end

  assign bus.addr  = req_addr;
  assign bus.wdata = acc_q; // Masked on the pins unless write is set
  assign bus.write = req_write;

endmodule

`default_nettype wire

// ==== hw/cpu_handler_top.sv ====
// CPU bus handler top: accumulator CPU framed onto an 8-bit output and 8-bit bidirectional pad ring
`timescale 1ns/1ns
`default_nettype none

module cpu_handler_top #(
  parameter int idle_cycles = 0 // Idle gap between frames
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ena,     // Pin compatibility only
  input  logic [7:0] ui_in,   // Pin compatibility only
  input  logic [7:0] uio_in,
  output logic [7:0] uo_out,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);

  logic [bus_frame_pkg::phase_w-1:0] phase;
  logic                              idle;
  logic                              unused_in;

  cpu_bus_if i_bus ();

  frame_sequencer #(
    .idle_cycles (idle_cycles)
  ) i_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .phase (phase),
    .idle  (idle),
    .bus   (i_bus.pins)
  );

  pin_serializer i_ser (
    .clk     (clk),
    .rst_n   (rst_n),
    .phase   (phase),
    .idle    (idle),
    .bus     (i_bus.pins),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  accum_cpu i_cpu (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (i_bus.cpu)
  );

  assign unused_in = &{ena, ui_in, 1'b0};

endmodule

`default_nettype wire

// ==== sim/cpu_handler_props.sv ====
// CPU handler properties: pin direction, idle gap and step strobe spacing
`timescale 1ns/1ns
`default_nettype none

module cpu_handler_props #(
  parameter int idle_cycles = 0
) (
  input logic       clk,
  input logic       rst_n,
  input logic [7:0] uio_oe,
  input logic       idle,
  input logic       step
);

  localparam int frame_len = bus_frame_pkg::frame_phases + idle_cycles;

  logic [7:0] since_step; // Cycles since the last step

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      since_step <= 8'(frame_len - 1); // First cycle after reset steps
    end else if (step) begin
      since_step <= '0;
    end else begin
      since_step <= since_step + 8'd1;
    end
  end

  // Whole byte drive in the five cycles after step, whole byte float elsewhere
  oe_follows_frame: assert property (@(posedge clk) disable iff (!rst_n)
    uio_oe == ((since_step < 8'd5) ? 8'hff : 8'h00))
    else $error("uio_oe does not match the frame phase");

  oe_low_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    idle |=> (uio_oe == 8'h00)) else $error("uio_oe driven in the idle gap");

  step_once_per_frame: assert property (@(posedge clk) disable iff (!rst_n)
    step == (since_step == 8'(frame_len - 1))) else $error("step spacing is not one frame");

endmodule

bind cpu_handler_top cpu_handler_props #(
  .idle_cycles (idle_cycles)
) i_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .uio_oe (uio_oe),
  .idle   (idle),
  .step   (i_bus.step)
);

`default_nettype wire

// ==== sim/bus_checker.sv ====
// Bus checker: decodes each frame on the pins and compares it with the expected access list
`timescale 1ns/1ns
`default_nettype none

module bus_checker #(
  parameter int idle_cycles = 0,
  parameter int max_acc     = 32
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  uo_out,
  input  logic [7:0]  uio_out,
  input  logic [7:0]  uio_oe,
  input  int          exp_count,
  input  logic [31:0] exp_addr  [max_acc],
  input  logic        exp_write [max_acc],
  input  logic [31:0] exp_wdata [max_acc],
  input  int          exp_tag   [max_acc],
  output int          err_count,
  output logic        done
);

  localparam int frame_len = bus_frame_pkg::frame_phases + idle_cycles;

  int          errs     = 0;
  logic        done_q   = 1'b0;
  logic        rst_seen = 1'b0; // Pins are unknown before the first reset edge
  int          pos;
  int          frame;
  int          idx;
  logic [31:0] cap_addr;
  logic [31:0] cap_wdata;
  logic [7:0]  exp_oe;
  string       name;

  assign err_count = errs;
  assign done      = done_q;

  function automatic string test_name(int tag);
    case (tag)
      0:       return "reset_quiet";
      2:       return "load_store";
      3:       return "addi_wrap";
      4:       return "jump_halt";
      default: return "seq_fetch";
    endcase
  endfunction

  task automatic report(string tname, string what, logic [31:0] exp, logic [31:0] act);
    $display("ERR %s %s expected %h actual %h", tname, what, exp, act);
    errs++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      if (rst_seen) begin
        if (uo_out !== 8'h00) report("reset_quiet", "uo_out", 32'h0, 32'(uo_out));
        if (uio_out !== 8'h00) report("reset_quiet", "uio_out", 32'h0, 32'(uio_out));
        if (uio_oe !== 8'h00) report("reset_quiet", "uio_oe", 32'h0, 32'(uio_oe));
      end
      rst_seen = 1'b1;
      pos   = 0;
      frame = 0;
      idx   = 0;
    end else begin
      name   = (frame == 0) ? "reset_quiet" : "seq_fetch";
      exp_oe = (pos >= 1 && pos <= 5) ? 8'hff : 8'h00;
      if (uio_oe !== exp_oe) report(name, "uio_oe", 32'(exp_oe), 32'(uio_oe));
      if (pos == 0 || pos >= 6) begin // Step, read window and idle keep outputs low
        if (uo_out !== 8'h00) report(name, "uo_out", 32'h0, 32'(uo_out));
        if (uio_out !== 8'h00) report(name, "uio_out", 32'h0, 32'(uio_out));
      end else if (pos <= 4) begin
        cap_addr[8*(pos-1) +: 8]  = uo_out;
        cap_wdata[8*(pos-1) +: 8] = uio_out;
      end else begin
        if (uo_out[7:1] !== 7'h0) report(name, "flag byte", 32'h0, 32'(uo_out));
        if (uio_out !== 8'h00) report(name, "uio_out", 32'h0, 32'(uio_out));
        if (idx < exp_count) begin
          name = test_name(exp_tag[idx]);
          if (cap_addr !== exp_addr[idx]) report(name, "address", exp_addr[idx], cap_addr);
          if (uo_out[0] !== exp_write[idx]) begin
            report(name, "write flag", 32'(exp_write[idx]), 32'(uo_out[0]));
          end
          if (exp_write[idx] && cap_wdata !== exp_wdata[idx]) begin
            report(name, "write data", exp_wdata[idx], cap_wdata);
          end else if (!exp_write[idx] && cap_wdata !== 32'h0) begin
            report(name, "read frame data pins", 32'h0, cap_wdata);
          end
          idx++;
          if (idx == exp_count) done_q = 1'b1;
        end
      end
      if (pos == frame_len - 1) begin
        pos = 0;
        frame++;
      end else begin
        pos++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_cpu_handler.sv ====
// CPU handler testbench: program table, external memory model on the pins and the closing verdict
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_handler;

  localparam int idle_cycles = 2;
  localparam int frame_len   = bus_frame_pkg::frame_phases + idle_cycles;
  localparam int max_acc     = 32;
  localparam int n_rows      = 13;
  localparam int mem_words   = 64;

  // Test tags, named in the checker
  localparam int tag_reset = 0;
  localparam int tag_seq   = 1;
  localparam int tag_ldst  = 2;
  localparam int tag_addi  = 3;
  localparam int tag_jump  = 4;

  logic       clk;
  logic       rst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  // Program and data table: address, word, test tag
  logic [31:0] row_addr [n_rows];
  logic [31:0] row_word [n_rows];
  int          row_tag  [n_rows];

  logic [31:0] mem     [mem_words]; // External memory seen on the pins
  logic [31:0] ref_mem [mem_words]; // Memory of the reference model
  int          tag_of  [mem_words];

  // Expected access list
  logic [31:0] exp_addr  [max_acc];
  logic        exp_write [max_acc];
  logic [31:0] exp_wdata [max_acc];
  int          exp_tag   [max_acc];
  int          exp_count;

  int          err_count;
  logic        done;
  int          seed;
  int          cycles;
  int          limit;
  int          timeout_errs;

  cpu_handler_top #(
    .idle_cycles (idle_cycles)
  ) i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .ena     (ena),
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  bus_checker #(
    .idle_cycles (idle_cycles),
    .max_acc     (max_acc)
  ) i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .exp_count (exp_count),
    .exp_addr  (exp_addr),
    .exp_write (exp_write),
    .exp_wdata (exp_wdata),
    .exp_tag   (exp_tag),
    .err_count (err_count),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] encode(cpu_isa_pkg::opcode_e op, logic [27:0] operand);
    return {op, operand};
  endfunction

  task automatic set_row(int i, logic [31:0] a, logic [31:0] w, int tag);
    row_addr[i] = a;
    row_word[i] = w;
    row_tag[i]  = tag;
  endtask

  task automatic push_access(logic [31:0] a, logic wr, logic [31:0] wd, int tag);
    exp_addr[exp_count]  = a;
    exp_write[exp_count] = wr;
    exp_wdata[exp_count] = wd;
    exp_tag[exp_count]   = tag;
    exp_count++;
  endtask

  // Runs the ISA rules over the table until halt has been fetched three times
  task automatic build_expected();
    logic [31:0] pc;
    logic [31:0] acc;
    logic [31:0] w;
    logic [31:0] operand;
    int          halts;
    int          ftag;
    pc    = '0;
    acc   = '0;
    halts = 0;
    exp_count = 0;
    while (halts < 3 && exp_count < max_acc - 2) begin
      w       = ref_mem[pc[5:0]];
      operand = {4'h0, w[27:0]};
      ftag    = (tag_of[pc[5:0]] == tag_jump) ? tag_jump : tag_seq;
      push_access(pc, 1'b0, 32'h0, (exp_count == 0) ? tag_reset : ftag);
      case (cpu_isa_pkg::opcode_e'(w[31:28]))
        cpu_isa_pkg::op_load: begin
          push_access(operand, 1'b0, 32'h0, tag_of[pc[5:0]]);
          acc = ref_mem[operand[5:0]];
          pc  = pc + 32'd1;
        end
        cpu_isa_pkg::op_store: begin
          push_access(operand, 1'b1, acc, tag_of[pc[5:0]]);
          ref_mem[operand[5:0]] = acc;
          pc = pc + 32'd1;
        end
        cpu_isa_pkg::op_addi: begin
          acc = acc + operand;
          pc  = pc + 32'd1;
        end
        cpu_isa_pkg::op_jump: pc = operand;
        default: halts++;
      endcase
    end
  endtask

  // External memory: tracks the frame from reset, applies writes, drives read bytes
  int          mpos;
  int          mnxt;
  logic [31:0] m_addr;
  logic [31:0] m_wdata;

  always @(posedge clk) begin
    if (!rst_n) begin
      mpos = 0;
      uio_in <= 8'h00;
    end else begin
      if (mpos >= 1 && mpos <= 4) begin
        m_addr[8*(mpos-1) +: 8]  = uo_out;
        m_wdata[8*(mpos-1) +: 8] = uio_out;
      end else if (mpos == 5 && uo_out[0]) begin
        mem[m_addr[5:0]] = m_wdata;
      end
      mnxt = (mpos == frame_len - 1) ? 0 : mpos + 1;
      if (mnxt >= 6 && mnxt <= 9) begin
        uio_in <= mem[m_addr[5:0]][8*(mnxt-6) +: 8];
      end else begin
        uio_in <= 8'h00;
      end
      mpos = mnxt;
    end
  end

  initial begin
    logic [31:0] rnd_word;
    rst_n  = 1'b0;
    ena    = 1'b1;
    ui_in  = 8'h00;
    uio_in = 8'h00;
    seed   = 9;
    timeout_errs = 0;
    rnd_word = $random(seed);

    set_row(0,  32'h00, encode(cpu_isa_pkg::op_load,  28'h20), tag_ldst);
    set_row(1,  32'h01, encode(cpu_isa_pkg::op_store, 28'h21), tag_ldst);
    set_row(2,  32'h02, encode(cpu_isa_pkg::op_load,  28'h22), tag_addi);
    set_row(3,  32'h03, encode(cpu_isa_pkg::op_addi,  28'h20), tag_addi);
    set_row(4,  32'h04, encode(cpu_isa_pkg::op_store, 28'h23), tag_addi);
    set_row(5,  32'h05, encode(cpu_isa_pkg::op_jump,  28'h08), tag_jump);
    set_row(6,  32'h06, encode(cpu_isa_pkg::op_halt,  28'h0),  tag_jump);
    set_row(7,  32'h07, encode(cpu_isa_pkg::op_halt,  28'h0),  tag_jump);
    set_row(8,  32'h08, encode(cpu_isa_pkg::op_halt,  28'h0),  tag_jump);
    set_row(9,  32'h20, rnd_word,     tag_ldst); // Random data row
    set_row(10, 32'h21, 32'h0,        tag_ldst);
    set_row(11, 32'h22, 32'hfffffff0, tag_addi);
    set_row(12, 32'h23, 32'h0,        tag_addi);

    for (int a = 0; a < mem_words; a++) begin
      mem[a]    = {4'hf, 28'(a)}; // Unused words decode as halt
      tag_of[a] = tag_seq;
    end
    for (int i = 0; i < n_rows; i++) begin
      mem[row_addr[i][5:0]]    = row_word[i];
      tag_of[row_addr[i][5:0]] = row_tag[i];
    end
    ref_mem = mem;
    for (int i = 0; i < max_acc; i++) begin
      exp_addr[i]  = '0;
      exp_write[i] = 1'b0;
      exp_wdata[i] = '0;
      exp_tag[i]   = 0;
    end
    build_expected();
    limit = exp_count * 12 + 16 + 20;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    cycles = 16;
    while (!done && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("Timeout after %0d cycles, the program did not reach halt", cycles);
      timeout_errs = 1;
    end
    $display("Errors: %0d checker, %0d timeout, %0d total", err_count, timeout_errs,
             err_count + timeout_errs);
    if (err_count + timeout_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hw/bus_frame_pkg.sv
hw/cpu_isa_pkg.sv
hw/cpu_bus_if.sv
hw/frame_sequencer.sv
hw/pin_serializer.sv
hw/accum_cpu.sv
hw/cpu_handler_top.sv
sim/cpu_handler_props.sv
sim/bus_checker.sv
sim/tb_cpu_handler.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the CPU handler testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_cpu_handler -o sim_tb

out="$(./obj_dir/sim_tb)"
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
else
  exit 1
fi
